// ==== Bender.yml ====
package:
  name: stream_match

sources:
  - verilog/stream_match_pkg.sv
  - verilog/keyword_matcher.sv
  - verilog/stream_context.sv
  - verilog/stream_enable_regs.sv
  - verilog/stream_tracker.sv
  - verilog/stream_match_top.sv
  - target: simulation
    files:
      - sim/stream_match_tb.sv

// ==== project.f ====
verilog/stream_match_pkg.sv
verilog/keyword_matcher.sv
verilog/stream_context.sv
verilog/stream_enable_regs.sv
verilog/stream_tracker.sv
verilog/stream_match_top.sv
sim/stream_match_tb.sv

// ==== sim/stream_match_tb.sv ====
module stream_match_tb;

   timeunit 1ns;
   timeprecision 1ps;

   // Rows in the packet table
   localparam int N_PKT = 18;

   logic                                     clk;
   logic                                     rst_n;
   logic                                     pkt_start;
   logic [stream_match_pkg::STREAM_ID_W-1:0] stream_id;
   logic [stream_match_pkg::CHAR_W-1:0]      char_in;
   logic                                     char_vld;
   logic                                     pkt_end;
   logic                                     cfg_wr;
   logic [stream_match_pkg::STREAM_ID_W-1:0] cfg_id;
   logic                                     cfg_enable;
   logic [stream_match_pkg::COUNT_W-1:0]     count;
   logic                                     fired;

   // Packet table
   // A '.' in the payload is a random filler byte
   int unsigned tbl_id    [N_PKT];
   bit          tbl_en    [N_PKT];
   string       tbl_data  [N_PKT];
   bit          tbl_fired [N_PKT];
   string       tbl_name  [N_PKT];
   int          n_entries;

   // Reference model state
   // model_len holds the keyword bytes matched so far per stream
   int          model_len  [stream_match_pkg::NUM_STREAMS];
   bit          model_seen [stream_match_pkg::NUM_STREAMS];
   bit          model_en   [stream_match_pkg::NUM_STREAMS];
   logic [stream_match_pkg::COUNT_W-1:0] exp_count;
   bit          exp_fired;

   int          count_errs;
   int          fired_errs;
   int          model_errs;
   int          seed;
   int          cycle_cnt;
   int          cycle_limit;

   stream_match_top stream_match_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_start  (pkt_start),
      .stream_id  (stream_id),
      .char_in    (char_in),
      .char_vld   (char_vld),
      .pkt_end    (pkt_end),
      .cfg_wr     (cfg_wr),
      .cfg_id     (cfg_id),
      .cfg_enable (cfg_enable),
      .count      (count),
      .fired      (fired)
   );

   // 10 ns clock
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Cycle limit of the whole run
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic add_entry(input int unsigned id, input bit en, input string data,
                            input bit hit, input string name);
      tbl_id[n_entries]    = id;
      tbl_en[n_entries]    = en;
      tbl_data[n_entries]  = data;
      tbl_fired[n_entries] = hit;
      tbl_name[n_entries]  = name;
      n_entries++;
   endtask

   // Filler never holds a keyword byte, so it always resets the automaton
   function automatic logic [stream_match_pkg::CHAR_W-1:0] fill_byte();
      logic [31:0]                         r;
      logic [stream_match_pkg::CHAR_W-1:0] b;
      b = "P";
      while (b == "P" || b == "A" || b == "S" || b == "V")
      begin
         r = $random(seed);
         b = r[stream_match_pkg::CHAR_W-1:0];
      end
      return b;
   endfunction

   // One byte through the keyword rule
   // len counts keyword bytes matched
   // A miss restarts at one byte when the byte is "P"
   function automatic int step_keyword(input int len,
                                       input logic [stream_match_pkg::CHAR_W-1:0] c,
                                       output bit hit);
      logic [31:0] kw;
      kw  = "PASV";
      hit = 1'b0;
      if (c == kw[31-8*len -: 8])
      begin
         if (len == 3)
         begin
            hit = 1'b1;
            return 0;
         end
         return len + 1;
      end
      if (c == "P")
         return 1;
      return 0;
   endfunction

   task automatic check_count(input string name,
                              input logic [stream_match_pkg::COUNT_W-1:0] expected,
                              input logic [stream_match_pkg::COUNT_W-1:0] actual);
      if (actual !== expected)
      begin
         count_errs++;
         $display("FAILED %s: count expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_fired(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         fired_errs++;
         $display("FAILED %s: fired expected %0b, actual %0b", name, expected, actual);
      end
   endtask

   // Runs one table row through enable write, packet, prediction and checks
   task automatic run_packet(input int idx);
      logic [stream_match_pkg::CHAR_W-1:0] payload [$];
      logic [stream_match_pkg::CHAR_W-1:0] b;
      string                               data;
      int                                  sid;
      int                                  len;
      bit                                  hit;
      bit                                  step_hit;
      sid  = tbl_id[idx];
      data = tbl_data[idx];
      for (int i = 0; i < data.len(); i++)
      begin
         if (data[i] == ".")
            b = fill_byte();
         else
            b = data[i];
         payload.push_back(b);
      end
      // Prediction
      // Unseen streams start with nothing matched
      model_en[sid] = tbl_en[idx];
      len = model_seen[sid] ? model_len[sid] : 0;
      model_seen[sid] = 1'b1;
      hit = 1'b0;
      foreach (payload[i])
      begin
         len = step_keyword(len, payload[i], step_hit);
         hit = hit | step_hit;
      end
      if (model_en[sid])
      begin
         model_len[sid] = len;
         exp_count      = exp_count + hit;
         exp_fired      = hit;
      end
      else
      begin
         exp_fired = 1'b0;
      end
      if (exp_fired != tbl_fired[idx])
      begin
         model_errs++;
         $display("Reference model and table disagree on fired for %s", tbl_name[idx]);
      end
      // Enable write lands before the packet opens
      @(posedge clk);
      cfg_wr     <= 1'b1;
      cfg_id     <= stream_match_pkg::STREAM_ID_W'(sid);
      cfg_enable <= tbl_en[idx];
      @(posedge clk);
      cfg_wr    <= 1'b0;
      pkt_start <= 1'b1;
      stream_id <= stream_match_pkg::STREAM_ID_W'(sid);
      @(posedge clk);
      pkt_start <= 1'b0;
      // The matcher restores in the second idle cycle
      @(posedge clk);
      foreach (payload[i])
      begin
         @(posedge clk);
         char_vld <= 1'b1;
         char_in  <= payload[i];
      end
      @(posedge clk);
      char_vld <= 1'b0;
      pkt_end  <= 1'b1;
      @(posedge clk);
      pkt_end <= 1'b0;
      // Commit is visible one cycle after pkt_end
      @(negedge clk);
      check_count(tbl_name[idx], exp_count, count);
      check_fired(tbl_name[idx], exp_fired, fired);
   endtask

   initial
   begin
      int max_len;
      rst_n      = 1'b0;
      pkt_start  = 1'b0;
      stream_id  = '0;
      char_in    = '0;
      char_vld   = 1'b0;
      pkt_end    = 1'b0;
      cfg_wr     = 1'b0;
      cfg_id     = '0;
      cfg_enable = 1'b0;
      count_errs = 0;
      fired_errs = 0;
      model_errs = 0;
      cycle_cnt  = 0;
      n_entries  = 0;
      seed       = 32'hfe30;
      exp_count  = '0;
      exp_fired  = 1'b0;
      for (int s = 0; s < stream_match_pkg::NUM_STREAMS; s++)
      begin
         model_len[s]  = 0;
         model_seen[s] = 1'b0;
         model_en[s]   = 1'b0;
      end

      // Stream, enable, payload, expected fired, name
      add_entry(1, 1, "..PASV..", 1, "basic_hit");
      add_entry(1, 1, "PASV.PASV", 1, "double_hit");
      add_entry(2, 1, "..PAP..A", 0, "no_keyword");
      add_entry(3, 1, "..PA", 0, "split_first");
      add_entry(3, 1, "SV..", 1, "split_second");
      add_entry(4, 1, ".PA", 0, "split_a_first");
      add_entry(5, 1, "...", 0, "split_other");
      add_entry(4, 1, "SV.", 1, "split_a_second");
      // Saved "PA" must survive the disabled packet
      add_entry(6, 1, "..PA", 0, "resume_save");
      add_entry(6, 0, ".PASV.", 0, "disabled_hit");
      add_entry(6, 1, "SV", 1, "resume_hit");
      add_entry(7, 1, "..PAS", 0, "pas_tail");
      add_entry(8, 1, "V..", 0, "new_idle");
      add_entry(8, 1, "PPASV", 1, "near_miss_pp");
      add_entry(9, 1, "PASPASV", 1, "near_miss_pas");
      add_entry(10, 1, "PASV", 1, "cfg_on");
      add_entry(10, 0, "PASV", 0, "cfg_off");
      add_entry(10, 1, ".PASV", 1, "cfg_on_again");

      max_len = 0;
      for (int i = 0; i < n_entries; i++)
      begin
         if (tbl_data[i].len() > max_len)
            max_len = tbl_data[i].len();
      end
      cycle_limit = n_entries * (max_len + 8) + 100;

      // Reset for 4 cycles
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_count("reset", '0, count);
      check_fired("reset", 1'b0, fired);

      for (int i = 0; i < n_entries; i++)
         run_packet(i);

      $display("Errors: count %0d, fired %0d, model %0d", count_errs, fired_errs, model_errs);
      if (count_errs + fired_errs + model_errs == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== verilog/keyword_matcher.sv ====
module keyword_matcher
(
   input  logic                                clk,
   input  logic                                rst_n,
   // Byte stream
   input  logic [stream_match_pkg::CHAR_W-1:0]   char_in,
   input  logic                                char_vld,
   // State restore from the stream context
   input  logic [stream_match_pkg::MSTATE_W-1:0] restore_state,
   input  logic                                restore_vld,
   // Current state, saved at packet end
   output logic [stream_match_pkg::MSTATE_W-1:0] match_state,
   // One-cycle pulse per completed keyword
   output logic                                match
);

   logic [stream_match_pkg::MSTATE_W-1:0] state_q;
   logic [stream_match_pkg::MSTATE_W-1:0] state_nxt;
   logic [stream_match_pkg::MSTATE_W-1:0] restart;
   logic                                 match_q;
   logic                                 match_nxt;

   // Fallback target on a mismatch
   // A "P" can always begin a new attempt
   // No other prefix of "PASV" is also a suffix, so this is exact
   assign restart = (char_in == stream_match_pkg::KW_0) ?
                    stream_match_pkg::MSTATE_P : stream_match_pkg::MSTATE_IDLE;

   always_comb
   begin
      state_nxt = state_q;
      match_nxt = 1'b0;
      if (restore_vld)
      begin
         // Context switch, take the saved state of the new stream
         state_nxt = restore_state;
      end
      else if (char_vld)
      begin
         case (state_q)
            stream_match_pkg::MSTATE_IDLE:
            begin
               state_nxt = restart;
            end
            stream_match_pkg::MSTATE_P:
            begin
               if (char_in == stream_match_pkg::KW_1)
                  state_nxt = stream_match_pkg::MSTATE_PA;
               else
                  state_nxt = restart;
            end
            stream_match_pkg::MSTATE_PA:
            begin
               if (char_in == stream_match_pkg::KW_2)
                  state_nxt = stream_match_pkg::MSTATE_PAS;
               else
                  state_nxt = restart;
            end
            stream_match_pkg::MSTATE_PAS:
            begin
               // Last byte closes the keyword and drops back to idle
               if (char_in == stream_match_pkg::KW_3)
               begin
                  state_nxt = stream_match_pkg::MSTATE_IDLE;
                  match_nxt = 1'b1;
               end
               else
               begin
                  state_nxt = restart;
               end
            end
            default:
            begin
               // Unused encodings recover to idle
               state_nxt = stream_match_pkg::MSTATE_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= stream_match_pkg::MSTATE_IDLE;
         match_q <= 1'b0;
      end
      else
      begin
         state_q <= state_nxt;
         match_q <= match_nxt;
      end
   end

   assign match_state = state_q;
   assign match       = match_q;

   // Restore lands before the first byte of a packet
   // A byte in the restore cycle would be lost
   restore_byte_overlap: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(restore_vld && char_vld))
   else
      $error("keyword_matcher: byte arrived in the restore cycle");

endmodule

// ==== verilog/stream_context.sv ====
module stream_context
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   // Packet context from the tracker
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] cur_id,
   input  logic                                   load_state,
   input  logic                                   new_stream,
   input  logic                                   pkt_end,
   // Enable of the current stream
   input  logic                                   stream_enable,
   // Matcher results
   input  logic                                   match,
   input  logic [stream_match_pkg::MSTATE_W-1:0]    match_state,
   // Restore path to the matcher
   output logic [stream_match_pkg::MSTATE_W-1:0]    restore_state,
   output logic                                   restore_vld,
   // Results
   output logic [stream_match_pkg::COUNT_W-1:0]     count,
   output logic                                   fired
);

   // Saved matcher state, one entry per stream
   logic [stream_match_pkg::MSTATE_W-1:0] state_mem [stream_match_pkg::NUM_STREAMS];

   logic [stream_match_pkg::COUNT_W-1:0] count_q;
   logic                                fired_q;
   logic                                restore_vld_q;
   logic [stream_match_pkg::MSTATE_W-1:0] restore_state_q;
   logic                                pkt_hit;

   // Packet hit, also catches a match in the pkt_end cycle itself
   assign pkt_hit = fired_q | match;

   // Restore path
   // Fresh streams start from idle, known streams from their entry
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         restore_vld_q <= 1'b0;
      else
         restore_vld_q <= load_state;
   end

   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (new_stream)
            restore_state_q <= stream_match_pkg::MSTATE_IDLE;
         else
            restore_state_q <= state_mem[cur_id];
      end
   end

   // State save, enabled streams only
   // A disabled packet leaves the entry untouched
   always_ff @(posedge clk)
   begin
      if (pkt_end && stream_enable)
         state_mem[cur_id] <= match_state;
   end

   // Speculative flag and counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count_q <= '0;
         fired_q <= 1'b0;
      end
      else if (pkt_end)
      begin
         if (stream_enable)
         begin
            // Commit at most one per packet
            count_q <= count_q + stream_match_pkg::COUNT_W'(pkt_hit);
            fired_q <= pkt_hit;
         end
         else
         begin
            fired_q <= 1'b0;
         end
      end
      else if (match)
         fired_q <= 1'b1;
      else if (load_state)
         // New packet starts unmatched
         fired_q <= 1'b0;
   end

   assign restore_state = restore_state_q;
   assign restore_vld   = restore_vld_q;
   assign count         = count_q;
   assign fired         = fired_q;

   // Restore and commit belong to different packets
   load_commit_overlap: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(pkt_end && load_state))
   else
      $error("stream_context: pkt_end in the load_state cycle");

endmodule

// ==== verilog/stream_enable_regs.sv ====
module stream_enable_regs
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   // Configuration write strobe
   input  logic                                   cfg_wr,
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] cfg_id,
   input  logic                                   cfg_enable,
   // Stream of the open packet
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] cur_id,
   // Enable of that stream
   output logic                                   stream_enable
);

   // One enable bit per stream
   logic [stream_match_pkg::NUM_STREAMS-1:0] enable_q;

   // Write port
   // All streams disabled out of reset
   // A write shows on the next cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         enable_q <= '0;
      end
      else if (cfg_wr)
      begin
         enable_q[cfg_id] <= cfg_enable;
      end
   end

   // Read port
   // Steers commit and state save in the context block
   assign stream_enable = enable_q[cur_id];

endmodule

// ==== verilog/stream_match_pkg.sv ====
package stream_match_pkg;

   // Stream addressing
   // Six id bits cover every stream slot
   localparam int STREAM_ID_W = 6;
   localparam int NUM_STREAMS = 64;

   // Byte lane of the packet payload
   localparam int CHAR_W = 8;

   // Global match counter, wraps on overflow
   localparam int COUNT_W = 16;

   // Matcher state word
   // Three bits leave room for a longer keyword later
   localparam int MSTATE_W = 3;

   // Matcher states
   // Zero must stay the idle state
   // A fresh stream restores zero
   localparam logic [MSTATE_W-1:0] MSTATE_IDLE = 3'd0;
   // "P" seen
   localparam logic [MSTATE_W-1:0] MSTATE_P = 3'd1;
   // "PA" seen
   localparam logic [MSTATE_W-1:0] MSTATE_PA = 3'd2;
   // "PAS" seen, one byte short of a hit
   localparam logic [MSTATE_W-1:0] MSTATE_PAS = 3'd3;

   // Keyword bytes, ASCII "PASV"
   // FTP passive mode command
   localparam logic [CHAR_W-1:0] KW_0 = 8'h50;
   localparam logic [CHAR_W-1:0] KW_1 = 8'h41;
   localparam logic [CHAR_W-1:0] KW_2 = 8'h53;
   localparam logic [CHAR_W-1:0] KW_3 = 8'h56;

endpackage

// ==== verilog/stream_match_top.sv ====
module stream_match_top
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   // Packet framing
   input  logic                                   pkt_start,
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] stream_id,
   input  logic [stream_match_pkg::CHAR_W-1:0]      char_in,
   input  logic                                   char_vld,
   input  logic                                   pkt_end,
   // Enable configuration
   input  logic                                   cfg_wr,
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] cfg_id,
   input  logic                                   cfg_enable,
   // Results
   output logic [stream_match_pkg::COUNT_W-1:0]     count,
   output logic                                   fired
);

   // Tracker to context and enables
   logic [stream_match_pkg::STREAM_ID_W-1:0] cur_id;
   logic                                    load_state;
   logic                                    new_stream;
   logic                                    pkt_open;
   logic                                    stream_enable;
   // Context to matcher and back
   logic [stream_match_pkg::MSTATE_W-1:0]    restore_state;
   logic                                    restore_vld;
   logic [stream_match_pkg::MSTATE_W-1:0]    match_state;
   logic                                    match;

   stream_tracker stream_tracker_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pkt_start  (pkt_start),
      .stream_id  (stream_id),
      .pkt_end    (pkt_end),
      .cur_id     (cur_id),
      .load_state (load_state),
      .new_stream (new_stream),
      .pkt_open   (pkt_open)
   );

   stream_enable_regs stream_enable_regs_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg_wr        (cfg_wr),
      .cfg_id        (cfg_id),
      .cfg_enable    (cfg_enable),
      .cur_id        (cur_id),
      .stream_enable (stream_enable)
   );

   stream_context stream_context_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .cur_id        (cur_id),
      .load_state    (load_state),
      .new_stream    (new_stream),
      .pkt_end       (pkt_end),
      .stream_enable (stream_enable),
      .match         (match),
      .match_state   (match_state),
      .restore_state (restore_state),
      .restore_vld   (restore_vld),
      .count         (count),
      .fired         (fired)
   );

   keyword_matcher keyword_matcher_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_vld      (char_vld),
      .restore_state (restore_state),
      .restore_vld   (restore_vld),
      .match_state   (match_state),
      .match         (match)
   );

   // Enables only change between packets
   // A write inside a packet would split its commit decision
   cfg_while_open: assert property (
      @(posedge clk) disable iff (!rst_n)
      cfg_wr |-> !pkt_open)
   else
      $error("stream_match_top: cfg_wr while a packet is open");

endmodule

// ==== verilog/stream_tracker.sv ====
module stream_tracker
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   // Packet framing
   input  logic                                   pkt_start,
   input  logic [stream_match_pkg::STREAM_ID_W-1:0] stream_id,
   input  logic                                   pkt_end,
   // Packet context
   output logic [stream_match_pkg::STREAM_ID_W-1:0] cur_id,
   output logic                                   load_state,
   output logic                                   new_stream,
   output logic                                   pkt_open
);

   logic [stream_match_pkg::STREAM_ID_W-1:0] cur_id_q;
   logic                                    load_state_q;
   logic                                    new_stream_q;
   logic                                    pkt_open_q;
   // Streams seen since reset
   logic [stream_match_pkg::NUM_STREAMS-1:0] seen_q;

   // Id latch and seen vector
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cur_id_q <= '0;
         seen_q   <= '0;
      end
      else if (pkt_start)
      begin
         cur_id_q         <= stream_id;
         seen_q[stream_id] <= 1'b1;
      end
   end

   // Restore strobe one cycle after pkt_start
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         load_state_q <= 1'b0;
      else
         load_state_q <= pkt_start;
   end

   // New-stream decision rides with load_state
   // Taken from the seen bit before this packet sets it
   always_ff @(posedge clk)
   begin
      if (pkt_start)
         new_stream_q <= !seen_q[stream_id];
   end

   // Open packet window
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pkt_open_q <= 1'b0;
      else if (pkt_start)
         pkt_open_q <= 1'b1;
      else if (pkt_end)
         pkt_open_q <= 1'b0;
   end

   assign cur_id     = cur_id_q;
   assign load_state = load_state_q;
   assign new_stream = new_stream_q;
   assign pkt_open   = pkt_open_q;

   // Packets of all streams are serialized
   start_while_open: assert property (
      @(posedge clk) disable iff (!rst_n)
      pkt_start |-> !pkt_open_q)
   else
      $error("stream_tracker: pkt_start while a packet is open");

endmodule
